//--- common/yaw_config.svh
`ifndef YAW_CONFIG_SVH
`define YAW_CONFIG_SVH

// word widths
`define YAW_ANGLE_W 16
`define YAW_TRACK_W 18
`define YAW_REC_W 8

// angles in 1/16 degree
`define YAW_ANGLE_360 5760
`define YAW_ANGLE_270 4320
`define YAW_ANGLE_90 1440

// setpoint runs at four times angle resolution
`define YAW_TRACK_SCALE_SHIFT 2

// receiver stick values
`define YAW_STICK_CENTRE 125
`define YAW_THROTTLE_IDLE 10

// rate command scaling
`define YAW_RATE_SHIFT 2
`define YAW_RATE_LIMIT 250

`endif

//--- common/yaw_pkg.sv
`include "yaw_config.svh"

package yaw_pkg;

	// signed angle, 1/16 degree per lsb
	// 5760 is one full turn
	typedef logic signed [`YAW_ANGLE_W-1:0] angle_t;

	// heading setpoint in quarter angle units
	// 23040 is one full turn, wraps back into 0..23040
	typedef logic signed [`YAW_TRACK_W-1:0] track_t;

	// raw receiver stick value, 0 to 250
	typedef logic [`YAW_REC_W-1:0] rec_val_t;

endpackage

//--- filelist.f
+incdir+common
common/yaw_pkg.sv
yaw_angle/yaw_sequencer.sv
yaw_angle/yaw_heading_tracker.sv
yaw_angle/yaw_error_calc.sv
yaw_angle/yaw_rate_limiter.sv
yaw_angle/yaw_angle_top.sv
sim/yaw_assert.sv
sim/yaw_tb.sv

//--- sim/yaw_assert.sv
module yaw_assert (
	input logic us_clk,
	input logic resetn,
	input logic capture,
	input logic active,
	input logic complete
);

	int unsigned assert_fails = 0;   // summed into the testbench verdict

	a_no_overlap: assert property (@(posedge us_clk) disable iff (!resetn)
		!(active && complete))
	else begin
		assert_fails++;
		$error("active and complete are high together");
	end

	// complete is a single-cycle pulse
	a_complete_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
		complete |=> !complete)
	else begin
		assert_fails++;
		$error("complete stayed high for more than one cycle");
	end

	a_active_run: assert property (@(posedge us_clk) disable iff (!resetn)
		capture |=> active [*3])
	else begin
		assert_fails++;
		$error("active did not follow capture for three cycles");
	end

endmodule

bind yaw_sequencer yaw_assert u_assert (
	.us_clk   (us_clk),
	.resetn   (resetn),
	.capture  (capture),
	.active   (active),
	.complete (complete)
);

//--- sim/yaw_tb.sv
`include "yaw_config.svh"

module yaw_tb import yaw_pkg::*; ();

	localparam int track_full = `YAW_ANGLE_360 << `YAW_TRACK_SCALE_SHIFT;
	localparam int wait_limit = 20;   // cycles before a wait gives up

	logic     us_clk;
	logic     resetn;
	logic     start;
	rec_val_t throttle;
	rec_val_t yaw_stick;
	angle_t   imu_yaw;
	angle_t   body_yaw_angle;
	angle_t   yaw_angle_error;
	angle_t   yaw_rate_cmd;
	logic     active;
	logic     complete;

	int value_errors = 0;
	int timeout_errors = 0;
	int model_sp = 0;   // reference setpoint, kept across runs
	int exp_body;
	int exp_err;
	int exp_rate;

	yaw_angle_top u_dut (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.start           (start),
		.throttle        (throttle),
		.yaw_stick       (yaw_stick),
		.imu_yaw         (imu_yaw),
		.body_yaw_angle  (body_yaw_angle),
		.yaw_angle_error (yaw_angle_error),
		.yaw_rate_cmd    (yaw_rate_cmd),
		.active          (active),
		.complete        (complete)
	);

	always #20 us_clk = ~us_clk;

	task automatic check_angle(input string what, input angle_t got, input angle_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report_and_finish();
		int assert_errors;
		assert_errors = u_dut.u_sequencer.u_assert.assert_fails;
		$display("errors: %0d value, %0d timeout, %0d assertion",
			value_errors, timeout_errors, assert_errors);
		if (value_errors + timeout_errors + assert_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	// tracker, error and limiter rules applied to plain integers
	task automatic model_run(input rec_val_t thr, input rec_val_t stick, input angle_t imu);
		int   imu_i;
		logic idle_m;
		imu_i  = int'(imu);
		idle_m = (thr < `YAW_THROTTLE_IDLE);
		if (idle_m) begin
			model_sp = imu_i * 4;
		end else begin
			model_sp = model_sp + int'(stick) - `YAW_STICK_CENTRE;
			if (model_sp > track_full)
				model_sp -= track_full;
			else if (model_sp < 0)
				model_sp += track_full;
		end
		exp_body = idle_m ? imu_i : (model_sp >>> `YAW_TRACK_SCALE_SHIFT);
		if (idle_m)
			exp_err = 0;
		else if (exp_body > `YAW_ANGLE_270 && imu_i < `YAW_ANGLE_90)
			exp_err = `YAW_ANGLE_360 - exp_body + imu_i;
		else if (imu_i > `YAW_ANGLE_270 && exp_body < `YAW_ANGLE_90)
			exp_err = imu_i - `YAW_ANGLE_360 - exp_body;
		else
			exp_err = exp_body - imu_i;
		exp_rate = exp_err >>> `YAW_RATE_SHIFT;
		if (exp_rate > `YAW_RATE_LIMIT)
			exp_rate = `YAW_RATE_LIMIT;
		else if (exp_rate < -`YAW_RATE_LIMIT)
			exp_rate = -`YAW_RATE_LIMIT;
	endtask

	// leaves the caller just after edge k
	task automatic launch(input rec_val_t thr, input rec_val_t stick, input angle_t imu);
		@(posedge us_clk);
		throttle  <= thr;
		yaw_stick <= stick;
		imu_yaw   <= imu;
		start     <= 1'b1;
		@(posedge us_clk);
		start <= 1'b0;
	endtask

	// n counts falling edges after edge k, run begins at edge k+base
	task automatic wait_complete(input int base, inout int n);
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(negedge us_clk);
			n++;
			check_flag("active", active, (n > base) && (n <= base + 3));
			check_flag("complete", complete, n == base + 5);   // edge k+4
			seen = complete;
			if (!seen && n - base > wait_limit) begin
				timeout_errors++;
				$display("timeout: complete did not arrive within %0d cycles", wait_limit);
				report_and_finish();
			end
		end
	endtask

	task automatic check_results();
		check_angle("body_yaw_angle", body_yaw_angle, angle_t'(exp_body));
		check_angle("yaw_angle_error", yaw_angle_error, angle_t'(exp_err));
		check_angle("yaw_rate_cmd", yaw_rate_cmd, angle_t'(exp_rate));
	endtask

	task automatic run_once(input rec_val_t thr, input rec_val_t stick, input angle_t imu);
		int n;
		n = 0;
		model_run(thr, stick, imu);
		launch(thr, stick, imu);
		wait_complete(0, n);
		check_results();
	endtask

	task automatic test_reset();
		@(negedge us_clk);
		check_flag("active", active, 1'b0);
		check_flag("complete", complete, 1'b0);
		check_angle("body_yaw_angle", body_yaw_angle, '0);
		check_angle("yaw_angle_error", yaw_angle_error, '0);
		check_angle("yaw_rate_cmd", yaw_rate_cmd, '0);
	endtask

	task automatic test_idle();
		run_once(8'd5, 8'd200, 16'sd1000);
		run_once(8'd100, 8'd200, 16'sd1000);   // starts from 4 x imu
	endtask

	task automatic test_accumulate();
		run_once(8'd0, 8'd125, 16'sd5740);
		run_once(8'd100, 8'd250, 16'sd5700);   // past 360
		run_once(8'd100, 8'd0, 16'sd100);      // below 0
		run_once(8'd100, 8'd200, 16'sd3000);
		run_once(8'd100, 8'd40, 16'sd3000);
	endtask

	task automatic test_error_wrap();
		run_once(8'd0, 8'd125, 16'sd5600);
		run_once(8'd120, 8'd125, 16'sd160);
		run_once(8'd0, 8'd125, 16'sd160);
		run_once(8'd120, 8'd125, 16'sd5600);
		run_once(8'd0, 8'd125, 16'sd2000);
		run_once(8'd120, 8'd125, 16'sd1800);
	endtask

	task automatic test_rate();
		int i;
		run_once(8'd0, 8'd125, 16'sd3000);
		run_once(8'd120, 8'd125, 16'sd500);    // clamps high
		run_once(8'd0, 8'd125, 16'sd500);
		run_once(8'd120, 8'd125, 16'sd3000);   // clamps low
		run_once(8'd120, 8'd130, 16'sd520);    // small negative error
		for (i = 0; i < 24; i++)
			run_once(rec_val_t'($urandom_range(250, 0)), rec_val_t'($urandom_range(250, 0)),
				angle_t'($urandom_range(5759, 0)));
	endtask

	task automatic test_start_during_run();
		int n;
		int i;
		n = 0;
		model_run(8'd90, 8'd180, 16'sd2500);
		launch(8'd90, 8'd180, 16'sd2500);
		@(posedge us_clk);
		throttle  <= 8'd90;   // second run's inputs, captured at edge k+5
		yaw_stick <= 8'd60;
		imu_yaw   <= 16'sd2600;
		start     <= 1'b1;
		@(posedge us_clk);
		start <= 1'b0;
		n = 2;
		wait_complete(0, n);
		check_results();
		model_run(8'd90, 8'd60, 16'sd2600);
		wait_complete(5, n);
		check_results();
		for (i = 0; i < 8; i++) begin
			@(negedge us_clk);
			check_flag("active after second run", active, 1'b0);
		end
	endtask

	initial begin
		us_clk    = 1'b0;
		resetn    = 1'b0;
		start     = 1'b0;
		throttle  = '0;
		yaw_stick = 8'd125;
		imu_yaw   = '0;
		void'($urandom(64));
		repeat (3) @(posedge us_clk);
		resetn <= 1'b1;
		test_reset();
		test_idle();
		test_accumulate();
		test_error_wrap();
		test_rate();
		test_start_during_run();
		report_and_finish();
	end

endmodule

//--- yaw_angle/yaw_angle_top.sv
module yaw_angle_top import yaw_pkg::*; (
	input  logic     us_clk,
	input  logic     resetn,
	input  logic     start,
	input  rec_val_t throttle,
	input  rec_val_t yaw_stick,
	input  angle_t   imu_yaw,
	output angle_t   body_yaw_angle,
	output angle_t   yaw_angle_error,
	output angle_t   yaw_rate_cmd,
	output logic     active,
	output logic     complete
);

	logic   capture;
	logic   track_step;
	logic   body_step;
	logic   error_step;
	logic   idle;         // decided once per run in the tracker
	angle_t imu_sample;

	yaw_sequencer u_sequencer (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.start      (start),
		.capture    (capture),
		.track_step (track_step),
		.body_step  (body_step),
		.error_step (error_step),
		.active     (active),
		.complete   (complete)
	);

	yaw_heading_tracker u_tracker (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.capture    (capture),
		.track_step (track_step),
		.body_step  (body_step),
		.throttle   (throttle),
		.yaw_stick  (yaw_stick),
		.imu_yaw    (imu_yaw),
		.body_angle (body_yaw_angle),
		.imu_sample (imu_sample),
		.idle       (idle)
	);

	yaw_error_calc u_error (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.error_step      (error_step),
		.idle            (idle),
		.body_angle      (body_yaw_angle),
		.imu_sample      (imu_sample),
		.yaw_angle_error (yaw_angle_error)
	);

	yaw_rate_limiter u_limiter (
		.yaw_angle_error (yaw_angle_error),
		.yaw_rate_cmd    (yaw_rate_cmd)
	);

endmodule

//--- yaw_angle/yaw_error_calc.sv
`include "yaw_config.svh"

module yaw_error_calc import yaw_pkg::*; (
	input  logic   us_clk,
	input  logic   resetn,
	input  logic   error_step,
	input  logic   idle,
	input  angle_t body_angle,
	input  angle_t imu_sample,
	output angle_t yaw_angle_error
);

	localparam angle_t angle_360 = angle_t'(`YAW_ANGLE_360);
	localparam angle_t angle_270 = angle_t'(`YAW_ANGLE_270);
	localparam angle_t angle_90  = angle_t'(`YAW_ANGLE_90);

	angle_t err_next;
	logic   body_hi_imu_lo;   // body just under 360, imu just over 0
	logic   imu_hi_body_lo;

	assign body_hi_imu_lo = (body_angle > angle_270) && (imu_sample < angle_90);
	assign imu_hi_body_lo = (imu_sample > angle_270) && (body_angle < angle_90);

	// shortest path across the 0/360 seam
	always_comb begin
		if (idle)
			err_next = '0;
		else if (body_hi_imu_lo)
			err_next = (angle_360 - body_angle) + imu_sample;
		else if (imu_hi_body_lo)
			err_next = (imu_sample - angle_360) - body_angle;
		else
			err_next = body_angle - imu_sample;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			yaw_angle_error <= '0;
		else if (error_step)
			yaw_angle_error <= err_next;
	end

endmodule

//--- yaw_angle/yaw_heading_tracker.sv
`include "yaw_config.svh"

module yaw_heading_tracker import yaw_pkg::*; (
	input  logic     us_clk,
	input  logic     resetn,
	input  logic     capture,
	input  logic     track_step,
	input  logic     body_step,
	input  rec_val_t throttle,
	input  rec_val_t yaw_stick,
	input  angle_t   imu_yaw,
	output angle_t   body_angle,
	output angle_t   imu_sample,
	output logic     idle
);

	// full turn in setpoint units
	localparam track_t track_360 = track_t'(`YAW_ANGLE_360 << `YAW_TRACK_SCALE_SHIFT);
	localparam logic signed [9:0] stick_centre = 10'(`YAW_STICK_CENTRE);

	rec_val_t          yaw_q;
	track_t            track_q;
	track_t            track_sum;
	logic signed [9:0] stick_delta;   // -125 .. +125

	assign stick_delta = $signed({2'b00, yaw_q}) - stick_centre;
	assign track_sum   = track_q + track_t'(stick_delta);

	// stick sample, payload only
	always_ff @(posedge us_clk) begin
		if (capture)
			yaw_q <= yaw_stick;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			imu_sample <= '0;
			idle       <= 1'b0;
		end else if (capture) begin
			imu_sample <= imu_yaw;
			idle       <= (throttle < `YAW_THROTTLE_IDLE);
		end
	end

	// heading setpoint, kept across runs
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			track_q <= '0;
		end else if (track_step) begin
			if (idle)
				track_q <= track_t'(imu_sample) <<< `YAW_TRACK_SCALE_SHIFT;   // follow imu
			else if (track_sum > track_360)
				track_q <= track_sum - track_360;   // wrap past 360
			else if (track_sum < 0)
				track_q <= track_sum + track_360;   // wrap below 0
			else
				track_q <= track_sum;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			body_angle <= '0;
		else if (body_step)
			body_angle <= idle ? imu_sample
				: angle_t'(track_q >>> `YAW_TRACK_SCALE_SHIFT);   // back to angle units
	end

endmodule

//--- yaw_angle/yaw_rate_limiter.sv
`include "yaw_config.svh"

module yaw_rate_limiter import yaw_pkg::*; (
	input  angle_t yaw_angle_error,
	output angle_t yaw_rate_cmd
);

	localparam angle_t rate_max = angle_t'(`YAW_RATE_LIMIT);
	localparam angle_t rate_min = -rate_max;

	angle_t rate_raw;

	assign rate_raw = yaw_angle_error >>> `YAW_RATE_SHIFT;   // keeps sign

	// clamp to the rate loop's input range
	always_comb begin
		if (rate_raw > rate_max)
			yaw_rate_cmd = rate_max;
		else if (rate_raw < rate_min)
			yaw_rate_cmd = rate_min;
		else
			yaw_rate_cmd = rate_raw;
	end

endmodule

//--- yaw_angle/yaw_sequencer.sv
module yaw_sequencer (
	input  logic us_clk,
	input  logic resetn,
	input  logic start,
	output logic capture,
	output logic track_step,
	output logic body_step,
	output logic error_step,
	output logic active,
	output logic complete
);

	// one-hot state bit positions
	localparam int s_wait  = 0;
	localparam int s_track = 1;
	localparam int s_body  = 2;
	localparam int s_error = 3;
	localparam int s_done  = 4;

	logic [4:0] state;
	logic [4:0] state_next;
	logic       start_d;   // previous start, for edge detect
	logic       pending;   // start seen while busy
	logic       go;

	// launch a run from wait on a start level or a remembered edge
	assign go      = state[s_wait] & (start | pending);
	assign capture = go;   // inputs latch on the same edge

	always_comb begin
		state_next          = '0;
		state_next[s_wait]  = (state[s_wait] & ~go) | state[s_done];
		state_next[s_track] = go;
		state_next[s_body]  = state[s_track];
		state_next[s_error] = state[s_body];
		state_next[s_done]  = state[s_error];
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state    <= 5'b00001;
			start_d  <= 1'b0;
			pending  <= 1'b0;
			active   <= 1'b0;
			complete <= 1'b0;
		end else begin
			state   <= state_next;
			start_d <= start;
			// only one extra run is remembered
			if (go)
				pending <= 1'b0;
			else if (start && !start_d && !state[s_wait])
				pending <= 1'b1;
			active   <= go | state[s_track] | state[s_body];   // three cycles
			complete <= state[s_done];   // one cycle after the settle state
		end
	end

	// step strobes come straight from state flops
	assign track_step = state[s_track];
	assign body_step  = state[s_body];
	assign error_step = state[s_error];

endmodule
